// ==== rtl/corebus_resp_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width, depth and synchronizer constants for the core bus response
// clock-crossing path. Include it wherever the macros are needed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CORERESP_CONSTS_SVH
`define CORERESP_CONSTS_SVH

// Response payload fields.
`define CRESP_ID_WIDTH    8   // Transaction ID bits.
`define CRESP_DATA_WIDTH  32  // Response data bits.

// Async FIFO sizing.
`define CRESP_FIFO_DEPTH  8   // Entries, power of two, at least 4.

// Flops per Gray pointer synchronizer.
`define CRESP_SYNC_STAGES 2   // Use 3 for faster clocks.

`endif

// ==== rtl/corebus_resp_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by every stage of the response return path: the
// response kind encoding and the packed 44-bit response word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "corebus_resp_consts.svh"

package corebus_resp_pkg;

  // Kind of response returned to the requester.
  typedef enum logic [1:0] {
    RESP_READ      = 2'b00,  // Read data.
    RESP_WRITE_ACK = 2'b01,  // Posted write completion.
    RESP_ATOMIC    = 2'b10,  // Atomic result.
    RESP_MESSAGE   = 2'b11   // Message response.
  } resp_kind_e;

  // Full response word, kind in the top bits.
  typedef struct packed {
    resp_kind_e                   kind;   // Response kind.
    logic [`CRESP_ID_WIDTH-1:0]   id;     // Matches the request ID.
    logic                         error;  // Slave reported an error.
    logic                         last;   // Final beat of a burst.
    logic [`CRESP_DATA_WIDTH-1:0] data;   // Payload.
  } resp_t;

endpackage

// ==== rtl/resp_gray_sync.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flop chain that moves a Gray-coded FIFO pointer into the clock
// domain of i_clk. Used once per direction inside the async FIFO.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "corebus_resp_consts.svh"

module resp_gray_sync #(
  parameter int ADDR_WIDTH = 3,
  parameter int STAGES     = `CRESP_SYNC_STAGES
)(
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic [ADDR_WIDTH:0] i_gray,
  output logic [ADDR_WIDTH:0] o_gray
);

  // Stage 0 may go metastable; later stages settle it.
  logic [ADDR_WIDTH:0] sync_q [STAGES];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sync_q <= '{default: '0};
    end else begin
      sync_q[0] <= i_gray;  // Only one bit moves per step.
      for (int i = 1; i < STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign o_gray = sync_q[STAGES-1];  // Settled pointer.

endmodule

// ==== rtl/resp_async_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-clock FIFO for response words. Push and pop are transfers, so
// the caller must qualify them with full and empty.
// Pointers cross as Gray code with one extra wrap bit.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "corebus_resp_consts.svh"

module resp_async_fifo #(
  parameter int DEPTH  = `CRESP_FIFO_DEPTH,
  parameter int STAGES = `CRESP_SYNC_STAGES
)(
  input  logic                    i_wr_clk,
  input  logic                    i_wr_rst_n,
  input  logic                    i_push,
  input  corebus_resp_pkg::resp_t i_data,
  output logic                    o_full,
  input  logic                    i_rd_clk,
  input  logic                    i_rd_rst_n,
  input  logic                    i_pop,
  output corebus_resp_pkg::resp_t o_data,
  output logic                    o_empty
);
  import corebus_resp_pkg::*;

  localparam int ADDR_WIDTH = $clog2(DEPTH);

  logic [ADDR_WIDTH:0] wr_bin_q;
  logic [ADDR_WIDTH:0] wr_bin_next;
  logic [ADDR_WIDTH:0] wr_gray_q;
  logic [ADDR_WIDTH:0] rd_gray_wsync;  // Read pointer seen by the writer.
  logic [ADDR_WIDTH:0] rd_bin_q;
  logic [ADDR_WIDTH:0] rd_bin_next;
  logic [ADDR_WIDTH:0] rd_gray_q;
  logic [ADDR_WIDTH:0] wr_gray_rsync;  // Write pointer seen by the reader.
  resp_t               mem_q [DEPTH];

  function automatic logic [ADDR_WIDTH:0] bin_to_gray(input logic [ADDR_WIDTH:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // Write side.
  assign wr_bin_next = wr_bin_q + 1'b1;

  always_ff @(posedge i_wr_clk or negedge i_wr_rst_n) begin
    if (!i_wr_rst_n) begin
      wr_bin_q  <= '0;
      wr_gray_q <= '0;
    end else if (i_push) begin
      wr_bin_q  <= wr_bin_next;
      wr_gray_q <= bin_to_gray(wr_bin_next);
    end
  end

  always_ff @(posedge i_wr_clk) begin
    if (i_push) begin
      mem_q[wr_bin_q[ADDR_WIDTH-1:0]] <= i_data;
    end
  end

  // Writer is a full lap ahead when the top two Gray bits differ.
  assign o_full = (wr_gray_q == {~rd_gray_wsync[ADDR_WIDTH -: 2],
                                 rd_gray_wsync[ADDR_WIDTH-2:0]});

  // Read side.
  assign rd_bin_next = rd_bin_q + 1'b1;

  always_ff @(posedge i_rd_clk or negedge i_rd_rst_n) begin
    if (!i_rd_rst_n) begin
      rd_bin_q  <= '0;
      rd_gray_q <= '0;
    end else if (i_pop) begin
      rd_bin_q  <= rd_bin_next;
      rd_gray_q <= bin_to_gray(rd_bin_next);
    end
  end

  assign o_data  = mem_q[rd_bin_q[ADDR_WIDTH-1:0]];  // Head of the queue.
  assign o_empty = (rd_gray_q == wr_gray_rsync);

  resp_gray_sync #(
    .ADDR_WIDTH (ADDR_WIDTH ),
    .STAGES     (STAGES     )
  ) u_wr2rd_sync (
    .i_clk  (i_rd_clk       ),
    .i_rst_n(i_rd_rst_n     ),
    .i_gray (wr_gray_q      ),
    .o_gray (wr_gray_rsync  )
  );

  resp_gray_sync #(
    .ADDR_WIDTH (ADDR_WIDTH ),
    .STAGES     (STAGES     )
  ) u_rd2wr_sync (
    .i_clk  (i_wr_clk       ),
    .i_rst_n(i_wr_rst_n     ),
    .i_gray (rd_gray_q      ),
    .o_gray (rd_gray_wsync  )
  );

  // The slice upstream must never push into a full FIFO.
  a_no_push_full: assert property (
    @(posedge i_wr_clk) disable iff (!i_wr_rst_n) i_push |-> !o_full
  ) else $error("async fifo: push while full");

  a_no_pop_empty: assert property (
    @(posedge i_rd_clk) disable iff (!i_rd_rst_n) i_pop |-> !o_empty
  ) else $error("async fifo: pop while empty");

  // Synchronizers rely on single-bit pointer steps.
  a_wr_gray_step: assert property (
    @(posedge i_wr_clk) disable iff (!i_wr_rst_n)
      $countones(wr_gray_q ^ $past(wr_gray_q)) <= 1
  ) else $error("async fifo: write Gray pointer jumped");

  a_rd_gray_step: assert property (
    @(posedge i_rd_clk) disable iff (!i_rd_rst_n)
      $countones(rd_gray_q ^ $past(rd_gray_q)) <= 1
  ) else $error("async fifo: read Gray pointer jumped");

endmodule

// ==== rtl/resp_reg_slice.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry skid slice for response words. Output and accept both come
// from flops, and one transfer per cycle passes when nothing stalls.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module resp_reg_slice (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_valid,
  input  corebus_resp_pkg::resp_t i_data,
  output logic                    o_accept,
  output logic                    o_valid,
  output corebus_resp_pkg::resp_t o_data,
  input  logic                    i_accept
);
  import corebus_resp_pkg::*;

  logic  main_valid_q;
  resp_t main_data_q;
  logic  skid_valid_q;
  resp_t skid_data_q;
  logic  in_fire;
  logic  load_main;

  assign o_accept  = !skid_valid_q;          // Room while under two entries.
  assign in_fire   = i_valid && o_accept;
  assign load_main = !main_valid_q || i_accept;  // Main is free or draining.

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (load_main) begin
      main_valid_q <= skid_valid_q || in_fire;
      skid_valid_q <= 1'b0;                  // Skid drains into main.
    end else if (in_fire) begin
      skid_valid_q <= 1'b1;                  // Main is stuck, park it.
    end
  end

  always_ff @(posedge i_clk) begin
    if (load_main && (skid_valid_q || in_fire)) begin
      main_data_q <= skid_valid_q ? skid_data_q : i_data;  // Oldest first.
    end
    if (!load_main && in_fire) begin
      skid_data_q <= i_data;
    end
  end

  assign o_valid = main_valid_q;
  assign o_data  = main_data_q;

  // A stalled output must hold both valid and payload.
  a_hold_stalled: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      (o_valid && !i_accept) |=> (o_valid && $stable(o_data))
  ) else $error("reg slice: output changed while stalled");

endmodule

// ==== rtl/corebus_resp_cdc.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response return path of the core bus bridge. Carries responses from
// the master clock domain to the slave clock domain through an ingress
// slice, an async FIFO and an egress slice, keeping their order.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "corebus_resp_consts.svh"

module corebus_resp_cdc (
  input  logic                             i_master_clk,
  input  logic                             i_master_rst_n,
  input  logic                             i_master_sresp_valid,
  input  corebus_resp_pkg::resp_kind_e     i_master_sresp_kind,
  input  logic [`CRESP_ID_WIDTH-1:0]       i_master_sresp_id,
  input  logic                             i_master_sresp_error,
  input  logic                             i_master_sresp_last,
  input  logic [`CRESP_DATA_WIDTH-1:0]     i_master_sresp_data,
  output logic                             o_master_mresp_accept,
  input  logic                             i_slave_clk,
  input  logic                             i_slave_rst_n,
  output logic                             o_slave_sresp_valid,
  output corebus_resp_pkg::resp_kind_e     o_slave_sresp_kind,
  output logic [`CRESP_ID_WIDTH-1:0]       o_slave_sresp_id,
  output logic                             o_slave_sresp_error,
  output logic                             o_slave_sresp_last,
  output logic [`CRESP_DATA_WIDTH-1:0]     o_slave_sresp_data,
  input  logic                             i_slave_mresp_accept
);
  import corebus_resp_pkg::*;

  resp_t master_resp;
  resp_t ingress_data;
  resp_t fifo_rd_data;
  resp_t slave_resp;
  logic  ingress_valid;
  logic  fifo_full;
  logic  fifo_push;
  logic  fifo_empty;
  logic  fifo_pop;
  logic  egress_accept;

  assign master_resp = '{
    kind:  i_master_sresp_kind,
    id:    i_master_sresp_id,
    error: i_master_sresp_error,
    last:  i_master_sresp_last,
    data:  i_master_sresp_data
  };

  resp_reg_slice u_ingress_slice (
    .i_clk    (i_master_clk         ),
    .i_rst_n  (i_master_rst_n       ),
    .i_valid  (i_master_sresp_valid ),
    .i_data   (master_resp          ),
    .o_accept (o_master_mresp_accept),
    .o_valid  (ingress_valid        ),
    .o_data   (ingress_data         ),
    .i_accept (!fifo_full           )
  );

  assign fifo_push = ingress_valid && !fifo_full;  // Transfer into the FIFO.
  assign fifo_pop  = !fifo_empty && egress_accept; // Transfer out of it.

  resp_async_fifo u_async_fifo (
    .i_wr_clk   (i_master_clk   ),
    .i_wr_rst_n (i_master_rst_n ),
    .i_push     (fifo_push      ),
    .i_data     (ingress_data   ),
    .o_full     (fifo_full      ),
    .i_rd_clk   (i_slave_clk    ),
    .i_rd_rst_n (i_slave_rst_n  ),
    .i_pop      (fifo_pop       ),
    .o_data     (fifo_rd_data   ),
    .o_empty    (fifo_empty     )
  );

  resp_reg_slice u_egress_slice (
    .i_clk    (i_slave_clk          ),
    .i_rst_n  (i_slave_rst_n        ),
    .i_valid  (!fifo_empty          ),
    .i_data   (fifo_rd_data         ),
    .o_accept (egress_accept        ),
    .o_valid  (o_slave_sresp_valid  ),
    .o_data   (slave_resp           ),
    .i_accept (i_slave_mresp_accept )
  );

  assign o_slave_sresp_kind  = slave_resp.kind;
  assign o_slave_sresp_id    = slave_resp.id;
  assign o_slave_sresp_error = slave_resp.error;
  assign o_slave_sresp_last  = slave_resp.last;
  assign o_slave_sresp_data  = slave_resp.data;

endmodule

// ==== sim/clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running testbench clock. Starts low, waits OFFSET_NS, then
// toggles every half period. One instance per clock domain.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module clock_gen #(
  parameter real PERIOD_NS = 4.0,
  parameter real OFFSET_NS = 0.0
)(
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    #(OFFSET_NS);  // Phase shift against the other domain.
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

endmodule

// ==== sim/tb_corebus_resp_cdc.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the response clock-crossing path. Reads responses and
// slave stall counts from sim/resp_tests.txt, drives the master side,
// stalls the slave side and checks order, content and flow control.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "corebus_resp_consts.svh"

module tb_corebus_resp_cdc;
  import corebus_resp_pkg::*;

  localparam int NUM_TESTS  = 26;
  localparam int FIELDS     = 6;                      // Words per data line.
  localparam int MAX_FLIGHT = `CRESP_FIFO_DEPTH + 4;  // Both slices plus FIFO.
  localparam int TIMEOUT    = 200;                    // Cycles per wait loop.
  localparam int QUIET_WIN  = 40;

  logic                         master_clk;
  logic                         master_rst_n;
  logic                         master_sresp_valid;
  resp_kind_e                   master_sresp_kind;
  logic [`CRESP_ID_WIDTH-1:0]   master_sresp_id;
  logic                         master_sresp_error;
  logic                         master_sresp_last;
  logic [`CRESP_DATA_WIDTH-1:0] master_sresp_data;
  logic                         master_mresp_accept;
  logic                         slave_clk;
  logic                         slave_rst_n;
  logic                         slave_sresp_valid;
  resp_kind_e                   slave_sresp_kind;
  logic [`CRESP_ID_WIDTH-1:0]   slave_sresp_id;
  logic                         slave_sresp_error;
  logic                         slave_sresp_last;
  logic [`CRESP_DATA_WIDTH-1:0] slave_sresp_data;
  logic                         slave_mresp_accept;

  logic [31:0]              test_mem [0:NUM_TESTS*FIELDS-1];
  resp_t                    expected_q [$];
  int                       sent_count;
  int                       recv_count;
  logic                     long_stall;         // Slave is in a long stall.
  logic                     backpressure_seen;
  logic                     stalled_q;
  logic [$bits(resp_t)-1:0] held_word;
  logic [$bits(resp_t)-1:0] slave_word;

  clock_gen #(.PERIOD_NS(4.0), .OFFSET_NS(0.0)) u_master_clk_gen (.o_clk(master_clk));
  clock_gen #(.PERIOD_NS(4.0), .OFFSET_NS(1.3)) u_slave_clk_gen (.o_clk(slave_clk));

  corebus_resp_cdc corebus_resp_cdc_i (
    .i_master_clk          (master_clk         ),
    .i_master_rst_n        (master_rst_n       ),
    .i_master_sresp_valid  (master_sresp_valid ),
    .i_master_sresp_kind   (master_sresp_kind  ),
    .i_master_sresp_id     (master_sresp_id    ),
    .i_master_sresp_error  (master_sresp_error ),
    .i_master_sresp_last   (master_sresp_last  ),
    .i_master_sresp_data   (master_sresp_data  ),
    .o_master_mresp_accept (master_mresp_accept),
    .i_slave_clk           (slave_clk          ),
    .i_slave_rst_n         (slave_rst_n        ),
    .o_slave_sresp_valid   (slave_sresp_valid  ),
    .o_slave_sresp_kind    (slave_sresp_kind   ),
    .o_slave_sresp_id      (slave_sresp_id     ),
    .o_slave_sresp_error   (slave_sresp_error  ),
    .o_slave_sresp_last    (slave_sresp_last   ),
    .o_slave_sresp_data    (slave_sresp_data   ),
    .i_slave_mresp_accept  (slave_mresp_accept )
  );

  assign slave_word = {slave_sresp_kind, slave_sresp_id, slave_sresp_error,
                       slave_sresp_last, slave_sresp_data};

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  // Builds the response held on one line of the data file.
  function automatic resp_t line_resp(input int idx);
    resp_t r;
    r.kind  = resp_kind_e'(test_mem[idx*FIELDS][1:0]);
    r.id    = test_mem[idx*FIELDS+1][`CRESP_ID_WIDTH-1:0];
    r.error = test_mem[idx*FIELDS+2][0];
    r.last  = test_mem[idx*FIELDS+3][0];
    r.data  = test_mem[idx*FIELDS+4][`CRESP_DATA_WIDTH-1:0];
    return r;
  endfunction

  task automatic drive_responses();
    resp_t r;
    int    waited;
    @(negedge master_clk);
    for (int i = 0; i < NUM_TESTS; i++) begin
      r = line_resp(i);
      master_sresp_valid = 1'b1;
      master_sresp_kind  = r.kind;
      master_sresp_id    = r.id;
      master_sresp_error = r.error;
      master_sresp_last  = r.last;
      master_sresp_data  = r.data;
      waited = 0;
      @(posedge master_clk);
      while (!master_mresp_accept) begin
        waited++;
        if (waited > TIMEOUT) begin
          report_failure("master response was never accepted");
        end
        @(posedge master_clk);
      end
      expected_q.push_back(r);  // Transfer on this edge.
      sent_count++;
      check_value("in_flight_within_limit", 64'((sent_count - recv_count) <= MAX_FLIGHT),
                  64'd1);
      @(negedge master_clk);
    end
    master_sresp_valid = 1'b0;
  endtask

  task automatic receive_responses();
    resp_t exp;
    int    stall;
    int    waited;
    @(negedge slave_clk);
    for (int i = 0; i < NUM_TESTS; i++) begin
      stall             = int'(test_mem[i*FIELDS+5]) + int'($urandom % 4);
      long_stall        = (test_mem[i*FIELDS+5] > MAX_FLIGHT);
      backpressure_seen = 1'b0;
      if (stall > 0) begin
        slave_mresp_accept = 1'b0;
        repeat (stall) @(negedge slave_clk);
      end
      if (long_stall) begin
        check_value("backpressure_seen", backpressure_seen, 1);
      end
      long_stall         = 1'b0;
      slave_mresp_accept = 1'b1;
      waited = 0;
      @(posedge slave_clk);
      while (!slave_sresp_valid) begin
        waited++;
        if (waited > TIMEOUT) begin
          report_failure("slave side never saw a valid response");
        end
        @(posedge slave_clk);
      end
      if (expected_q.size() == 0) begin
        report_failure("a response came out that was never sent");
      end
      exp = expected_q.pop_front();
      check_value("o_slave_sresp_kind", slave_sresp_kind, exp.kind);
      check_value("o_slave_sresp_id", slave_sresp_id, exp.id);
      check_value("o_slave_sresp_error", slave_sresp_error, exp.error);
      check_value("o_slave_sresp_last", slave_sresp_last, exp.last);
      check_value("o_slave_sresp_data", slave_sresp_data, exp.data);
      recv_count++;
      @(negedge slave_clk);
    end
  endtask

  // Master accept must fall while the slave holds a long stall.
  always @(posedge master_clk) begin
    if (long_stall && !master_mresp_accept) begin
      backpressure_seen = 1'b1;
    end
  end

  // A stalled output keeps its fields until the next edge.
  always @(posedge slave_clk) begin
    if (slave_rst_n) begin
      if (stalled_q) begin
        check_value("o_slave_sresp fields", slave_word, held_word);
      end
      stalled_q = slave_sresp_valid && !slave_mresp_accept;
      held_word = slave_word;
    end
  end

  initial begin
    int waited;
    void'($urandom(21663));
    master_rst_n       = 1'b0;
    master_sresp_valid = 1'b0;
    master_sresp_kind  = RESP_READ;
    master_sresp_id    = '0;
    master_sresp_error = 1'b0;
    master_sresp_last  = 1'b0;
    master_sresp_data  = '0;
    slave_rst_n        = 1'b0;
    slave_mresp_accept = 1'b0;
    sent_count         = 0;
    recv_count         = 0;
    long_stall         = 1'b0;
    backpressure_seen  = 1'b0;
    stalled_q          = 1'b0;
    held_word          = '0;
    $readmemh("sim/resp_tests.txt", test_mem);
    fork
      begin
        repeat (3) @(posedge master_clk);
        @(negedge master_clk);
        master_rst_n = 1'b1;
      end
      begin
        repeat (3) @(posedge slave_clk);
        @(negedge slave_clk);
        slave_rst_n = 1'b1;
      end
    join
    check_value("o_slave_sresp_valid", slave_sresp_valid, 0);
    waited = 0;
    while (!master_mresp_accept) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_failure("master accept stayed low after reset");
      end
      @(negedge master_clk);
    end
    fork
      drive_responses();
      receive_responses();
    join
    repeat (QUIET_WIN) begin
      @(posedge slave_clk);
      check_value("o_slave_sresp_valid", slave_sresp_valid, 0);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== sim/resp_tests.txt ====
// Columns, all hex: kind id error last data stall
// kind 0 read, 1 write-ack, 2 atomic, 3 message; stall counts slave clock cycles
0 01 0 0 a5a50001 0
0 01 0 1 a5a50002 0
1 02 0 1 00000000 1
2 03 0 1 12345678 2
3 04 0 1 cafef00d 0
0 05 1 0 deadbeef 18
0 05 0 0 0badf00d 0
0 05 0 1 13572468 0
1 06 1 1 00000000 0
2 07 0 1 ffffffff 3
3 08 0 1 80000001 0
0 09 0 0 11111111 1
0 09 0 0 22222222 0
0 09 0 0 33333333 0
0 09 0 1 44444444 5
1 0a 0 1 00000000 0
1 0b 1 1 00000000 2
2 0c 1 1 5a5a5a5a 0
3 0d 1 1 0f0f0f0f 4
0 fe 0 0 76543210 0
0 fe 0 1 fedcba98 9
2 ff 0 1 00000001 0
3 80 0 1 c0ffee00 1
1 7f 0 1 00000000 0
0 10 0 0 0000ffff 0
0 10 0 1 ffff0000 2

// ==== corebus_resp_cdc.f ====
+incdir+rtl
rtl/corebus_resp_pkg.sv
rtl/resp_gray_sync.sv
rtl/resp_async_fifo.sv
rtl/resp_reg_slice.sv
rtl/corebus_resp_cdc.sv
sim/clock_gen.sv
sim/tb_corebus_resp_cdc.sv

// ==== Makefile ====
# Verilator build and run of the response clock-crossing testbench.

TOP  := tb_corebus_resp_cdc
BIN  := obj_dir/V$(TOP)
SRCS := $(filter-out +%,$(shell cat corebus_resp_cdc.f)) rtl/corebus_resp_consts.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): corebus_resp_cdc.f $(SRCS)
	verilator --binary --assert -Wno-fatal -j 0 --top-module $(TOP) -f corebus_resp_cdc.f

# Passes only if the run prints the pass message.
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
